// File: logic/pdp8_config.svh
`ifndef PDP8_CONFIG_SVH
`define PDP8_CONFIG_SVH

// Machine word, also the address width
`define PDP8_WORD_W 12

// Core memory size in words
`define PDP8_MEM_DEPTH 4096

// Offset inside one 128-word page
`define PDP8_PAGE_W 7

// Auto-index pointers, octal 0010 through 0017
`define PDP8_AUTO_LO 12'o0010
`define PDP8_AUTO_HI 12'o0017

`endif

// File: logic/pdp8Pkg.sv
`include "pdp8_config.svh"

package pdp8Pkg;

  // One machine word
  typedef logic [`PDP8_WORD_W-1:0] word_t;

  // Core address, sized from the memory depth
  typedef logic [$clog2(`PDP8_MEM_DEPTH)-1:0] addr_t;

  // Major opcode, IR bits 0..2 in DEC numbering
  typedef enum logic [2:0] {
    opAnd = 3'd0,
    opTad = 3'd1,
    opIsz = 3'd2,
    opDca = 3'd3,
    opJms = 3'd4,
    opJmp = 3'd5,
    opIot = 3'd6,
    opOpr = 3'd7
  } opcode_t;

  // Sequencer major states
  typedef enum logic [2:0] {
    sHalted,
    sFetch,
    sDecode,
    sAutoinc,
    sDefer,
    sExec,
    sSkip
  } seqState_t;

endpackage

// File: logic/memBus.sv
// One memory requester to the arbiter
// Requester holds req and fields until grant
// Grant is the access cycle, rdata follows one cycle later
interface memBus;
  import pdp8Pkg::*;

  logic req;
  logic we;
  addr_t addr;
  word_t wdata;
  logic grant;
  word_t rdata;

  modport requester (
    output req, we, addr, wdata,
    input grant, rdata
  );

  // Arbiter side
  modport arbiter (
    input req, we, addr, wdata,
    output grant, rdata
  );

endinterface

// File: logic/execCtl.sv
// Sequencer to execution unit handoff
interface execCtl;
  import pdp8Pkg::*;

  logic start;
  opcode_t op;
  addr_t ea;
  // IR bits 3..11, operate microcode
  logic [8:0] micro;
  logic done;
  // Skip and halt are valid with done
  logic skip;
  logic haltReq;

  modport sequencer (
    output start, op, ea, micro,
    input done, skip, haltReq
  );

  modport exec (
    input start, op, ea, micro,
    output done, skip, haltReq
  );

endinterface

// File: logic/coreMemory.sv
`include "pdp8_config.svh"

module coreMemory (
  input logic CLK,
  input logic en,
  input logic we,
  input pdp8Pkg::addr_t addr,
  input pdp8Pkg::word_t wdata,
  output pdp8Pkg::word_t rdata
);
  import pdp8Pkg::*;

  // Core array, contents undefined at power-up
  word_t mem [`PDP8_MEM_DEPTH];

  // Registered read, old data on a write cycle
  always_ff @(posedge CLK) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

// File: logic/memArbiter.sv
module memArbiter (
  input logic CLK,
  input logic arstN,
  input logic deposit,
  input logic examine,
  input pdp8Pkg::addr_t panelAddr,
  input pdp8Pkg::word_t panelData,
  output pdp8Pkg::word_t examData,
  output logic examValid,
  memBus.arbiter seqBus,
  memBus.arbiter exeBus
);
  import pdp8Pkg::*;

  logic panelPend;
  logic panelWe;
  addr_t panelAddrQ;
  word_t panelDataQ;
  logic panelGrant;
  logic memEn;
  logic memWe;
  addr_t memAddr;
  word_t memWdata;
  word_t memRdata;

  // Panel strobe waits here until served
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      panelPend <= 1'b0;
      examValid <= 1'b0;
    end else begin
      if (deposit || examine) begin
        panelPend <= 1'b1;
      end else if (panelGrant) begin
        panelPend <= 1'b0;
      end
      // Read data comes out one cycle after the grant
      examValid <= panelGrant && !panelWe;
    end
  end

  always_ff @(posedge CLK) begin
    if (deposit || examine) begin
      panelWe <= deposit;
      panelAddrQ <= panelAddr;
      panelDataQ <= panelData;
    end
  end

  // Fixed priority: panel, sequencer, execution unit
  assign panelGrant = panelPend;
  assign seqBus.grant = !panelPend && seqBus.req;
  assign exeBus.grant = !panelPend && !seqBus.req && exeBus.req;

  always_comb begin
    if (panelPend) begin
      memWe = panelWe;
      memAddr = panelAddrQ;
      memWdata = panelDataQ;
    end else if (seqBus.req) begin
      memWe = seqBus.we;
      memAddr = seqBus.addr;
      memWdata = seqBus.wdata;
    end else begin
      memWe = exeBus.we;
      memAddr = exeBus.addr;
      memWdata = exeBus.wdata;
    end
  end

  assign memEn = panelPend || seqBus.req || exeBus.req;

  // Same read data to every requester
  assign seqBus.rdata = memRdata;
  assign exeBus.rdata = memRdata;
  assign examData = memRdata;

  coreMemory core (
    .CLK(CLK),
    .en(memEn),
    .we(memWe),
    .addr(memAddr),
    .wdata(memWdata),
    .rdata(memRdata)
  );

endmodule

// File: logic/instrSequencer.sv
`include "pdp8_config.svh"

module instrSequencer (
  input logic CLK,
  input logic arstN,
  input logic run,
  input logic halt,
  input logic stepInstr,
  input logic loadPc,
  input pdp8Pkg::addr_t panelAddr,
  memBus.requester memPort,
  execCtl.sequencer exe,
  output pdp8Pkg::addr_t pc,
  output logic running,
  output logic instrDone
);
  import pdp8Pkg::*;

  seqState_t state;
  // Step inside a memory state: 0 request, 1 read data, 2 write back
  logic [1:0] phase;
  word_t ir;
  addr_t ea;
  addr_t ptr;
  logic [`PDP8_WORD_W-`PDP8_PAGE_W-1:0] fetchPage;
  logic [`PDP8_WORD_W-`PDP8_PAGE_W-1:0] pageBase;
  addr_t directAddr;
  addr_t resolved;
  opcode_t op;
  logic indirect;
  logic memRef;
  logic autoPtr;
  logic addrDone;
  logic finishing;
  logic stopNow;
  logic startQ;
  logic haltPend;
  logic stepQ;

  assign op = opcode_t'(ir[`PDP8_WORD_W-1 -: 3]);
  assign indirect = ir[`PDP8_PAGE_W+1];
  assign memRef = (op != opIot) && (op != opOpr);

  // Page bit picks current page or page zero
  assign pageBase = ir[`PDP8_PAGE_W] ? fetchPage : '0;
  assign directAddr = {pageBase, ir[`PDP8_PAGE_W-1:0]};
  assign autoPtr = (directAddr >= `PDP8_AUTO_LO) && (directAddr <= `PDP8_AUTO_HI);

  // Final address after defer or auto-index
  assign resolved = (state == sDefer) ? memPort.rdata : ptr;
  assign addrDone = (state == sDefer && phase == 2'd1)
                 || (state == sAutoinc && phase == 2'd2 && memPort.grant);

  // Instruction ends here
  assign finishing = (state == sDecode && op == opJmp && !indirect)
                  || (addrDone && op == opJmp)
                  || (state == sExec && exe.done && !exe.skip)
                  || (state == sSkip);
  assign stopNow = haltPend || halt || stepQ || (state == sExec && exe.haltReq);

  assign memPort.req = ((state == sFetch || state == sDefer || state == sAutoinc)
                        && phase == 2'd0)
                    || (state == sAutoinc && phase == 2'd2);
  assign memPort.we = (phase == 2'd2);
  assign memPort.addr = (state == sFetch) ? pc : ea;
  assign memPort.wdata = ptr;

  assign exe.start = startQ;
  assign exe.op = op;
  assign exe.ea = ea;
  assign exe.micro = ir[8:0];

  always_ff @(posedge CLK) begin
    if (state == sFetch && phase == 2'd1) begin
      ir <= memPort.rdata;
      // Page of the instruction itself, before the PC moves on
      fetchPage <= pc[`PDP8_WORD_W-1:`PDP8_PAGE_W];
    end
    if (state == sDecode) begin
      ea <= directAddr;
    end else if (addrDone) begin
      ea <= resolved;
    end
    if (state == sAutoinc && phase == 2'd1) begin
      ptr <= memPort.rdata + addr_t'(1);
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state <= sHalted;
      phase <= 2'd0;
      pc <= '0;
      running <= 1'b0;
      instrDone <= 1'b0;
      startQ <= 1'b0;
      haltPend <= 1'b0;
      stepQ <= 1'b0;
    end else begin
      instrDone <= 1'b0;
      startQ <= 1'b0;
      if (halt) begin
        haltPend <= 1'b1;
      end
      // Running drops the cycle after the last instrDone
      if (instrDone && state == sHalted) begin
        running <= 1'b0;
      end
      // Any granted request moves on to its data cycle
      if (memPort.grant && phase == 2'd0) begin
        phase <= 2'd1;
      end
      case (state)
        sHalted: begin
          haltPend <= 1'b0;
          if (loadPc) begin
            pc <= panelAddr;
          end
          if (run || stepInstr) begin
            running <= 1'b1;
            stepQ <= !run;
            state <= sFetch;
          end
        end
        sFetch: begin
          if (phase == 2'd1) begin
            pc <= pc + addr_t'(1);
            phase <= 2'd0;
            state <= sDecode;
          end
        end
        sDecode: begin
          if (memRef && indirect) begin
            state <= autoPtr ? sAutoinc : sDefer;
          end else if (op == opJmp) begin
            pc <= directAddr;
          end else begin
            state <= sExec;
            startQ <= 1'b1;
          end
        end
        sDefer, sAutoinc: begin
          if (state == sAutoinc && phase == 2'd1) begin
            phase <= 2'd2;
          end
          if (addrDone) begin
            phase <= 2'd0;
            if (op == opJmp) begin
              pc <= resolved;
            end else begin
              state <= sExec;
              startQ <= 1'b1;
            end
          end
        end
        sExec: begin
          // Skip costs one extra cycle for the PC bump
          if (exe.done && exe.skip) begin
            state <= sSkip;
            if (exe.haltReq) begin
              haltPend <= 1'b1;
            end
          end
        end
        sSkip: pc <= pc + addr_t'(1);
        default: state <= sHalted;
      endcase
      if (finishing) begin
        instrDone <= 1'b1;
        stepQ <= 1'b0;
        if (stopNow) begin
          state <= sHalted;
          haltPend <= 1'b0;
        end else begin
          state <= sFetch;
        end
      end
    end
  end

endmodule

// File: logic/execUnit.sv
`include "pdp8_config.svh"

module execUnit (
  input logic CLK,
  input logic arstN,
  memBus.requester memPort,
  execCtl.exec exe,
  output pdp8Pkg::word_t ac,
  output logic link
);
  import pdp8Pkg::*;

  typedef enum logic [2:0] {
    eIdle,
    eMem,
    eData,
    eIncr,
    eWrite,
    eDone
  } exeState_t;

  exeState_t state;
  word_t dataQ;
  logic skipQ;
  logic haltQ;
  logic memOp;
  logic [`PDP8_WORD_W:0] tadSum;
  word_t stepAc;
  logic stepLink;
  logic [`PDP8_WORD_W:0] incSum;
  logic [`PDP8_WORD_W:0] g1Lac;
  logic [`PDP8_WORD_W:0] rotLac;
  logic g2Skip;

  assign memOp = exe.op inside {opAnd, opTad, opIsz, opDca};

  // Request goes out in the start cycle, held until granted
  assign memPort.req = (state == eIdle && exe.start && memOp)
                    || (state == eMem) || (state == eWrite);
  assign memPort.we = (state == eWrite) || (exe.op == opDca);
  assign memPort.addr = exe.ea;
  assign memPort.wdata = (state == eWrite) ? dataQ : ac;

  assign exe.done = (state == eDone);
  assign exe.skip = skipQ;
  assign exe.haltReq = haltQ;

  // TAD carry out complements link
  assign tadSum = {1'b0, ac} + {1'b0, memPort.rdata};

  // Group 1: clears first, then complements
  assign stepAc = (exe.micro[7] ? '0 : ac) ^ {`PDP8_WORD_W{exe.micro[5]}};
  assign stepLink = (exe.micro[6] ? 1'b0 : link) ^ exe.micro[4];
  // Then IAC, carry flips link
  assign incSum = {1'b0, stepAc} + {{`PDP8_WORD_W{1'b0}}, exe.micro[0]};
  assign g1Lac = {stepLink ^ incSum[`PDP8_WORD_W], incSum[`PDP8_WORD_W-1:0]};

  // Rotates through link as bit 12, BSW swaps 6-bit halves
  always_comb begin
    case (exe.micro[3:1])
      3'b100: rotLac = {g1Lac[0], g1Lac[12:1]};
      3'b101: rotLac = {g1Lac[1:0], g1Lac[12:2]};
      3'b010: rotLac = {g1Lac[11:0], g1Lac[12]};
      3'b011: rotLac = {g1Lac[10:0], g1Lac[12:11]};
      3'b001: rotLac = {g1Lac[12], g1Lac[5:0], g1Lac[11:6]};
      default: rotLac = g1Lac;
    endcase
  end

  // Group 2 OR of SMA SZA SNL, bit 3 inverts the sense
  assign g2Skip = ((exe.micro[6] && ac[`PDP8_WORD_W-1])
                || (exe.micro[5] && ac == '0)
                || (exe.micro[4] && link)) ^ exe.micro[3];

  always_ff @(posedge CLK) begin
    if (state == eData) begin
      dataQ <= memPort.rdata;
    end else if (state == eIncr) begin
      dataQ <= dataQ + word_t'(1);
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state <= eIdle;
      ac <= '0;
      link <= 1'b0;
      skipQ <= 1'b0;
      haltQ <= 1'b0;
    end else begin
      case (state)
        eIdle: begin
          if (exe.start) begin
            skipQ <= 1'b0;
            haltQ <= 1'b0;
            if (memOp) begin
              state <= memPort.grant ? eData : eMem;
            end else begin
              // Operate finishes in one cycle, JMS and IOT do nothing
              state <= eDone;
              if (exe.op == opOpr && !exe.micro[8]) begin
                ac <= rotLac[`PDP8_WORD_W-1:0];
                link <= rotLac[`PDP8_WORD_W];
              end else if (exe.op == opOpr && !exe.micro[0]) begin
                // Test sees AC before CLA
                skipQ <= g2Skip;
                haltQ <= exe.micro[1];
                if (exe.micro[7]) begin
                  ac <= '0;
                end
              end
            end
          end
        end
        eMem: begin
          if (memPort.grant) begin
            state <= eData;
          end
        end
        eData: begin
          case (exe.op)
            opAnd: ac <= ac & memPort.rdata;
            opTad: begin
              ac <= tadSum[`PDP8_WORD_W-1:0];
              link <= link ^ tadSum[`PDP8_WORD_W];
            end
            opDca: ac <= '0;
            default: ;
          endcase
          state <= (exe.op == opIsz) ? eIncr : eDone;
        end
        eIncr: begin
          // All ones wraps to zero
          skipQ <= (dataQ == '1);
          state <= eWrite;
        end
        eWrite: begin
          if (memPort.grant) begin
            state <= eDone;
          end
        end
        default: state <= eIdle;
      endcase
    end
  end

endmodule

// File: logic/pdp8Cpu.sv
module pdp8Cpu (
  input logic CLK,
  input logic arstN,
  input logic run,
  input logic halt,
  input logic stepInstr,
  input logic loadPc,
  input logic deposit,
  input logic examine,
  input pdp8Pkg::addr_t panelAddr,
  input pdp8Pkg::word_t panelData,
  output pdp8Pkg::word_t examData,
  output logic examValid,
  output pdp8Pkg::addr_t pc,
  output pdp8Pkg::word_t ac,
  output logic link,
  output logic running,
  output logic instrDone
);
  import pdp8Pkg::*;

  // One bus per CPU requester, panel enters through plain strobes
  memBus seqBus ();
  memBus exeBus ();
  execCtl exe ();

  memArbiter arbiter (
    .CLK(CLK),
    .arstN(arstN),
    .deposit(deposit),
    .examine(examine),
    .panelAddr(panelAddr),
    .panelData(panelData),
    .examData(examData),
    .examValid(examValid),
    .seqBus(seqBus.arbiter),
    .exeBus(exeBus.arbiter)
  );

  instrSequencer sequencer (
    .CLK(CLK),
    .arstN(arstN),
    .run(run),
    .halt(halt),
    .stepInstr(stepInstr),
    .loadPc(loadPc),
    .panelAddr(panelAddr),
    .memPort(seqBus.requester),
    .exe(exe.sequencer),
    .pc(pc),
    .running(running),
    .instrDone(instrDone)
  );

  execUnit execution (
    .CLK(CLK),
    .arstN(arstN),
    .memPort(exeBus.requester),
    .exe(exe.exec),
    .ac(ac),
    .link(link)
  );

endmodule

// File: dv/pdp8Props.sv
module pdp8Props (
  input logic CLK,
  input logic arstN,
  input logic [2:0] grants,
  input logic running,
  input logic instrDone
);

  int failCount = 0;

  // One memory owner per cycle at most
  grantOneHot: assert property (@(posedge CLK) disable iff (!arstN) $onehot0(grants))
    else begin
      failCount++;
      $error("memory grants overlap: %b", grants);
    end

  // Each grant is a single-cycle pulse
  grantPulse: assert property (@(posedge CLK) disable iff (!arstN)
    (grants & $past(grants)) == 3'b000)
    else begin
      failCount++;
      $error("a memory grant stayed high for two cycles");
    end

  donePulse: assert property (@(posedge CLK) disable iff (!arstN)
    instrDone |=> !instrDone)
    else begin
      failCount++;
      $error("instrDone stayed high for two cycles");
    end

  // Quiet while reset is held
  resetQuiet: assert property (@(posedge CLK) !arstN |-> !running && !instrDone)
    else begin
      failCount++;
      $error("running or instrDone high during reset");
    end

endmodule

bind memArbiter pdp8Props arbProps (
  .CLK(CLK),
  .arstN(arstN),
  .grants({panelGrant, seqBus.grant, exeBus.grant}),
  .running(1'b0),
  .instrDone(1'b0)
);

bind instrSequencer pdp8Props seqProps (
  .CLK(CLK),
  .arstN(arstN),
  .grants({2'b00, memPort.grant}),
  .running(running),
  .instrDone(instrDone)
);

// File: dv/pdp8Tb.sv
module pdp8Tb;
  import pdp8Pkg::*;

  localparam int ClkPeriod = 100;
  localparam int DriveDelay = 10;
  localparam int NumTests = 5;
  localparam int CyclesPerTest = 5000;
  localparam int WaitLimit = 400;

  logic CLK;
  logic arstN;
  logic run;
  logic halt;
  logic stepInstr;
  logic loadPc;
  logic deposit;
  logic examine;
  addr_t panelAddr;
  word_t panelData;
  word_t examData;
  logic examValid;
  addr_t pc;
  word_t ac;
  logic link;
  logic running;
  logic instrDone;

  logic [31:0] lcgState = 32'h5269;
  int errors = 0;
  int checks = 0;
  int testsRun = 0;
  int propFails;

  pdp8Cpu dut (
    .CLK(CLK),
    .arstN(arstN),
    .run(run),
    .halt(halt),
    .stepInstr(stepInstr),
    .loadPc(loadPc),
    .deposit(deposit),
    .examine(examine),
    .panelAddr(panelAddr),
    .panelData(panelData),
    .examData(examData),
    .examValid(examValid),
    .pc(pc),
    .ac(ac),
    .link(link),
    .running(running),
    .instrDone(instrDone)
  );

  initial begin
    CLK = 1'b0;
    forever #(ClkPeriod / 2) CLK = ~CLK;
  end

  // Budget covers every test at its worst case
  initial begin
    #(ClkPeriod * CyclesPerTest * NumTests);
    $display("Watchdog expired at %0t, the tests did not finish in time", $time);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic word_t lcgWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[27:16];
  endfunction

  // Memory-reference word from opcode, indirect, current page and offset
  function automatic word_t encodeMri(opcode_t op, logic ind, logic cur, logic [6:0] off);
    return {op, ind, cur, off};
  endfunction

  // Group 1 steps on {link, AC} in hardware order
  function automatic logic [12:0] group1Model(word_t acIn, logic linkIn, logic [8:0] micro);
    logic [12:0] lac;
    int rotations;
    lac = {linkIn, acIn};
    if (micro[7]) lac[11:0] = '0;
    if (micro[6]) lac[12] = 1'b0;
    if (micro[5]) lac[11:0] = ~lac[11:0];
    if (micro[4]) lac[12] = ~lac[12];
    // Carry out of AC lands in link
    if (micro[0]) lac = lac + 13'd1;
    rotations = (micro[3] || micro[2]) ? (micro[1] ? 2 : 1) : 0;
    if (micro[3:1] == 3'b001) lac = {lac[12], lac[5:0], lac[11:6]};
    for (int i = 0; i < rotations; i++) begin
      if (micro[3]) lac = {lac[0], lac[12:1]};
      else lac = {lac[11:0], lac[12]};
    end
    return lac;
  endfunction

  // Normal sense ORs the conditions and reversed sense ANDs their opposites
  function automatic logic expectSkip(word_t acIn, logic linkIn, logic [8:0] micro);
    logic anyHit;
    logic allClear;
    anyHit = (micro[6] && acIn[11]) || (micro[5] && acIn == 0) || (micro[4] && linkIn);
    allClear = (!micro[6] || !acIn[11]) && (!micro[5] || acIn != 0)
            && (!micro[4] || !linkIn);
    return micro[3] ? allClear : anyHit;
  endfunction

  task automatic nextCycle();
    @(posedge CLK);
    #DriveDelay;
  endtask

  task automatic compare(input string what, input logic [12:0] got, input logic [12:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %o, expected %o", $time, what, got, exp);
    end
  endtask

  task automatic depositWord(input addr_t addr, input word_t data);
    panelAddr = addr;
    panelData = data;
    deposit = 1'b1;
    nextCycle();
    deposit = 1'b0;
    // Write happens in the grant cycle after the strobe
    nextCycle();
  endtask

  task automatic examineWord(input addr_t addr, output word_t data);
    int waited;
    waited = 0;
    panelAddr = addr;
    examine = 1'b1;
    nextCycle();
    examine = 1'b0;
    nextCycle();
    while (!examValid && waited < WaitLimit) begin
      nextCycle();
      waited++;
    end
    if (!examValid) begin
      errors++;
      $display("Error at %0t: examine of %o never returned data", $time, addr);
    end
    data = examData;
  endtask

  task automatic loadPcTo(input addr_t addr);
    panelAddr = addr;
    loadPc = 1'b1;
    nextCycle();
    loadPc = 1'b0;
  endtask

  task automatic runToHalt(output int done);
    int waited;
    int sinceDone;
    done = 0;
    waited = 0;
    sinceDone = 0;
    run = 1'b1;
    nextCycle();
    run = 1'b0;
    while (running && waited < WaitLimit) begin
      nextCycle();
      waited++;
      if (instrDone) begin
        done++;
        sinceDone = 0;
      end else begin
        sinceDone++;
      end
    end
    if (running) begin
      errors++;
      $display("Error at %0t: program never reached a HLT", $time);
    end else begin
      // Running falls in the cycle after the halting instrDone
      compare("cycles from HLT instrDone to running low", sinceDone, 1);
    end
  endtask

  task automatic stepOne();
    int waited;
    int pulses;
    waited = 0;
    pulses = 0;
    stepInstr = 1'b1;
    nextCycle();
    stepInstr = 1'b0;
    while (running && waited < WaitLimit) begin
      nextCycle();
      waited++;
      if (instrDone) pulses++;
    end
    // Idle cycles catch a stray second instruction
    repeat (3) begin
      nextCycle();
      if (instrDone) pulses++;
    end
    if (running) begin
      errors++;
      $display("Error at %0t: processor kept running after a single step", $time);
    end
    compare("instrDone pulses per step", pulses, 1);
  endtask

  task automatic finishTest(input string name, input int startErr);
    testsRun++;
    if (errors == startErr) $display("Test %s passed", name);
    else $display("Test %s failed with %0d errors", name, errors - startErr);
  endtask

  task automatic memoryRoundTrip();
    addr_t addrs [8];
    word_t data [8];
    word_t a;
    word_t got;
    int startErr;
    startErr = errors;
    // Low bits from the index keep the addresses distinct
    for (int i = 0; i < 8; i++) begin
      a = lcgWord();
      addrs[i] = {a[11:3], i[2:0]};
      data[i] = lcgWord();
      depositWord(addrs[i], data[i]);
    end
    for (int i = 7; i >= 0; i--) begin
      examineWord(addrs[i], got);
      compare($sformatf("word at %o", addrs[i]), got, data[i]);
    end
    finishTest("deposit and examine", startErr);
  endtask

  task automatic arithProgram();
    word_t a;
    word_t b;
    word_t c;
    word_t got;
    logic [12:0] sum;
    int count;
    int startErr;
    startErr = errors;
    a = lcgWord();
    b = lcgWord();
    c = lcgWord();
    depositWord(12'o0200, 12'o7300);
    depositWord(12'o0201, encodeMri(opTad, 1'b0, 1'b1, 7'o50));
    depositWord(12'o0202, encodeMri(opTad, 1'b0, 1'b1, 7'o51));
    depositWord(12'o0203, encodeMri(opAnd, 1'b0, 1'b1, 7'o52));
    depositWord(12'o0204, 12'o7402);
    depositWord(12'o0205, encodeMri(opDca, 1'b0, 1'b1, 7'o53));
    depositWord(12'o0206, 12'o7402);
    depositWord(12'o0250, a);
    depositWord(12'o0251, b);
    depositWord(12'o0252, c);
    loadPcTo(12'o0200);
    runToHalt(count);
    // Link starts clear so it ends as the carry of a + b
    sum = a + b;
    compare("AC after TAD TAD AND", ac, sum[11:0] & c);
    compare("link after TAD carry", link, sum[12]);
    compare("instructions to first HLT", count, 5);
    compare("PC at first HLT", pc, 12'o0205);
    runToHalt(count);
    compare("AC after DCA", ac, 0);
    compare("link after DCA", link, sum[12]);
    examineWord(12'o0253, got);
    compare("word stored by DCA", got, sum[11:0] & c);
    finishTest("TAD AND DCA", startErr);
  endtask

  task automatic iszAndAutoIndex();
    word_t d;
    word_t got;
    int count;
    int startErr;
    startErr = errors;
    d = lcgWord();
    depositWord(12'o0400, 12'o7300);
    depositWord(12'o0401, encodeMri(opIsz, 1'b0, 1'b1, 7'o50));
    depositWord(12'o0402, encodeMri(opIsz, 1'b0, 1'b1, 7'o50));
    depositWord(12'o0403, 12'o7402);
    // Page zero 0012 is an auto-index pointer
    depositWord(12'o0404, encodeMri(opTad, 1'b1, 1'b0, 7'o12));
    depositWord(12'o0405, 12'o7402);
    depositWord(12'o0450, 12'o7776);
    depositWord(12'o0012, 12'o0457);
    depositWord(12'o0460, d);
    loadPcTo(12'o0400);
    stepOne();
    stepOne();
    compare("PC after first ISZ", pc, 12'o0402);
    examineWord(12'o0450, got);
    compare("counter after first ISZ", got, 12'o7777);
    // Second ISZ wraps and skips the HLT at 0403
    runToHalt(count);
    compare("instructions after wrap", count, 3);
    compare("PC at HLT", pc, 12'o0406);
    examineWord(12'o0450, got);
    compare("counter after wrap", got, 12'o0000);
    examineWord(12'o0012, got);
    compare("auto-index pointer", got, 12'o0460);
    compare("AC after indirect TAD", ac, d);
    compare("link after indirect TAD", link, 1'b0);
    finishTest("ISZ and auto-index", startErr);
  endtask

  task automatic group1Case(input word_t v, input logic l, input word_t instr);
    logic [12:0] exp;
    int count;
    depositWord(12'o0600, 12'o7300);
    depositWord(12'o0601, encodeMri(opTad, 1'b0, 1'b1, 7'o50));
    depositWord(12'o0602, l ? 12'o7020 : 12'o7000);
    depositWord(12'o0603, instr);
    depositWord(12'o0604, 12'o7402);
    depositWord(12'o0650, v);
    loadPcTo(12'o0600);
    runToHalt(count);
    exp = group1Model(v, l, instr[8:0]);
    compare("instructions in group 1 program", count, 5);
    compare($sformatf("AC after %o on %o", instr, v), ac, exp[11:0]);
    compare($sformatf("link after %o on %o", instr, v), link, exp[12]);
  endtask

  task automatic group1Combos();
    word_t combos [14] = '{12'o7200, 12'o7100, 12'o7040, 12'o7020, 12'o7001, 12'o7010,
                           12'o7004, 12'o7012, 12'o7006, 12'o7002, 12'o7241, 12'o7061,
                           12'o7124, 12'o7053};
    word_t v;
    word_t r;
    int startErr;
    startErr = errors;
    foreach (combos[i]) begin
      v = lcgWord();
      r = lcgWord();
      group1Case(v, r[0], combos[i]);
    end
    // IAC carry into link with and without a rotate
    group1Case(12'o7777, 1'b0, 12'o7001);
    group1Case(12'o7777, 1'b1, 12'o7005);
    finishTest("group 1 operate", startErr);
  endtask

  task automatic skipCase(input word_t v, input logic l, input word_t instr);
    logic skip;
    depositWord(12'o1000, 12'o7300);
    depositWord(12'o1001, encodeMri(opTad, 1'b0, 1'b1, 7'o50));
    depositWord(12'o1002, l ? 12'o7020 : 12'o7000);
    depositWord(12'o1003, instr);
    depositWord(12'o1004, 12'o7402);
    depositWord(12'o1005, 12'o7402);
    depositWord(12'o1050, v);
    loadPcTo(12'o1000);
    repeat (4) stepOne();
    skip = expectSkip(v, l, instr[8:0]);
    compare($sformatf("PC after %o on %o", instr, v), pc, skip ? 12'o1005 : 12'o1004);
    // CLA comes after the test
    compare($sformatf("AC after %o", instr), ac, instr[7] ? 12'o0000 : v);
  endtask

  task automatic group2SkipsAndJmp();
    word_t skips [11] = '{12'o7500, 12'o7440, 12'o7420, 12'o7510, 12'o7450, 12'o7430,
                          12'o7410, 12'o7540, 12'o7570, 12'o7640, 12'o7650};
    word_t v;
    word_t r;
    int count;
    int startErr;
    startErr = errors;
    foreach (skips[i]) begin
      r = lcgWord();
      case (i % 3)
        0: v = '0;
        1: v = r | 12'o4000;
        default: v = r;
      endcase
      r = lcgWord();
      skipCase(v, r[0], skips[i]);
    end
    // Direct JMP then JMP through a plain pointer
    depositWord(12'o1100, encodeMri(opJmp, 1'b0, 1'b1, 7'o120));
    depositWord(12'o1120, encodeMri(opJmp, 1'b1, 1'b1, 7'o121));
    depositWord(12'o1121, 12'o2200);
    depositWord(12'o2200, 12'o7402);
    loadPcTo(12'o1100);
    stepOne();
    compare("PC after direct JMP", pc, 12'o1120);
    stepOne();
    compare("PC after indirect JMP", pc, 12'o2200);
    runToHalt(count);
    compare("instructions to HLT", count, 1);
    compare("PC after HLT", pc, 12'o2201);
    finishTest("group 2 skips and JMP", startErr);
  endtask

  initial begin
    arstN = 1'b0;
    run = 1'b0;
    halt = 1'b0;
    stepInstr = 1'b0;
    loadPc = 1'b0;
    deposit = 1'b0;
    examine = 1'b0;
    panelAddr = '0;
    panelData = '0;
    repeat (2) @(posedge CLK);
    #DriveDelay;
    arstN = 1'b1;
    nextCycle();
    memoryRoundTrip();
    arithProgram();
    iszAndAutoIndex();
    group1Combos();
    group2SkipsAndJmp();
    propFails = dut.arbiter.arbProps.failCount + dut.sequencer.seqProps.failCount;
    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             testsRun, checks, errors, propFails);
    if (errors == 0 && propFails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
logic/pdp8Pkg.sv
logic/memBus.sv
logic/execCtl.sv
logic/coreMemory.sv
logic/memArbiter.sv
logic/instrSequencer.sv
logic/execUnit.sv
logic/pdp8Cpu.sv
dv/pdp8Props.sv
dv/pdp8Tb.sv

// File: Bender.yml
package:
  name: pdp8

sources:
  - include_dirs:
      - logic
    files:
      - logic/pdp8Pkg.sv
      - logic/memBus.sv
      - logic/execCtl.sv
      - logic/coreMemory.sv
      - logic/memArbiter.sv
      - logic/instrSequencer.sv
      - logic/execUnit.sv
      - logic/pdp8Cpu.sv
  - target: simulation
    files:
      - dv/pdp8Props.sv
      - dv/pdp8Tb.sv
